// ==== design/doa_pkg.sv ====
package doa_pkg;

    // antenna sample format
    localparam int din_width = 16;
    localparam int din_point = 14;

    // one extra bit for the sum and difference in the transform
    localparam int trans_width = din_width + 1;

    // product of two transformed values plus one bit for the add
    localparam int prod_width = 2 * trans_width + 1;

    // products are scaled by four ahead of requantization
    localparam int pre_acc_shift = 2;

    // accumulator input and output formats
    localparam int acc_in_width = 20;
    localparam int acc_in_point = 16;
    localparam int dout_width = 32;

    // frame layout
    localparam int vector_len = 16;
    localparam int bands = 4;
    localparam int band_step = vector_len / bands;

    typedef logic signed [din_width-1:0] sample_t;
    typedef logic signed [trans_width-1:0] trans_t;
    typedef logic signed [prod_width-1:0] prod_t;
    typedef logic signed [acc_in_width-1:0] acc_in_t;
    typedef logic signed [dout_width-1:0] sum_t;

    // band index
    typedef logic [$clog2(bands)-1:0] band_t;

    // sample index within a frame, must hold vector_len itself
    typedef logic [$clog2(vector_len+1)-1:0] count_t;

endpackage

// ==== design/centrosym_matrix.sv ====
`timescale 1ns/1ns

module centrosym_matrix (
    input  logic             clk,
    input  logic             rst,
    input  doa_pkg::sample_t x1_re,
    input  doa_pkg::sample_t x1_im,
    input  doa_pkg::sample_t x2_re,
    input  doa_pkg::sample_t x2_im,
    input  logic             din_valid,
    output doa_pkg::trans_t  y1_re,
    output doa_pkg::trans_t  y1_im,
    output doa_pkg::trans_t  y2_re,
    output doa_pkg::trans_t  y2_im,
    output logic             dout_valid
);
    import doa_pkg::*;

    // unitary transform for two elements, unscaled:
    // y1 = x1 + x2, y2 = -j * (x1 - x2)
    always_ff @(posedge clk) begin
        y1_re <= trans_t'(x1_re) + trans_t'(x2_re);
        y1_im <= trans_t'(x1_im) + trans_t'(x2_im);
        // rotated difference
        y2_re <= trans_t'(x1_im) - trans_t'(x2_im);
        y2_im <= trans_t'(x2_re) - trans_t'(x1_re);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

endmodule

// ==== design/correlation_mults.sv ====
`timescale 1ns/1ns

module correlation_mults (
    input  logic            clk,
    input  logic            rst,
    input  doa_pkg::trans_t y1_re,
    input  doa_pkg::trans_t y1_im,
    input  doa_pkg::trans_t y2_re,
    input  doa_pkg::trans_t y2_im,
    input  logic            din_valid,
    output doa_pkg::prod_t  r11,
    output doa_pkg::prod_t  r22,
    output doa_pkg::prod_t  r12_re,
    output doa_pkg::prod_t  r12_im,
    output logic            dout_valid
);
    import doa_pkg::*;

    // partial products, full width of a single multiply
    logic signed [2*trans_width-1:0] p1re_1re;
    logic signed [2*trans_width-1:0] p1im_1im;
    logic signed [2*trans_width-1:0] p2re_2re;
    logic signed [2*trans_width-1:0] p2im_2im;
    logic signed [2*trans_width-1:0] p1re_2re;
    logic signed [2*trans_width-1:0] p1im_2im;
    logic signed [2*trans_width-1:0] p1im_2re;
    logic signed [2*trans_width-1:0] p1re_2im;
    logic [1:0]                      valid_pipe;

    // stage 1
    always_ff @(posedge clk) begin
        p1re_1re <= y1_re * y1_re;
        p1im_1im <= y1_im * y1_im;
        p2re_2re <= y2_re * y2_re;
        p2im_2im <= y2_im * y2_im;
        p1re_2re <= y1_re * y2_re;
        p1im_2im <= y1_im * y2_im;
        p1im_2re <= y1_im * y2_re;
        p1re_2im <= y1_re * y2_im;
    end

    // stage 2, y1 * conj(y2) for the cross term
    always_ff @(posedge clk) begin
        r11    <= prod_t'(p1re_1re) + prod_t'(p1im_1im);
        r22    <= prod_t'(p2re_2re) + prod_t'(p2im_2im);
        r12_re <= prod_t'(p1re_2re) + prod_t'(p1im_2im);
        r12_im <= prod_t'(p1im_2re) - prod_t'(p1re_2im);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], din_valid};
        end
    end

    assign dout_valid = valid_pipe[1];

endmodule

// ==== design/signed_cast.sv ====
`timescale 1ns/1ns

module signed_cast (
    input  logic             clk,
    input  logic             rst,
    input  doa_pkg::prod_t   din,
    input  logic             din_valid,
    output doa_pkg::acc_in_t dout,
    output logic             dout_valid
);
    import doa_pkg::*;

    logic signed [prod_width+pre_acc_shift-1:0] gained;
    logic signed [prod_width+pre_acc_shift-1:0] scaled;
    // bits that must all match the output sign bit
    logic [prod_width+pre_acc_shift-acc_in_width:0] top_bits;
    logic fits;

    always_comb begin
        gained = (prod_width+pre_acc_shift)'(din) <<< pre_acc_shift;
        // floor rounding, surplus fraction bits just fall off
        scaled = gained >>> (2*din_point - acc_in_point);
        top_bits = scaled[prod_width+pre_acc_shift-1:acc_in_width-1];
        fits = (&top_bits) || (~|top_bits);
    end

    always_ff @(posedge clk) begin
        if (fits) begin
            dout <= scaled[acc_in_width-1:0];
        end else if (scaled[prod_width+pre_acc_shift-1]) begin
            dout <= {1'b1, {(acc_in_width-1){1'b0}}};
        end else begin
            dout <= {1'b0, {(acc_in_width-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

endmodule

// ==== design/band_accumulator.sv ====
`timescale 1ns/1ns

module band_accumulator (
    input  logic             clk,
    input  logic             rst,
    input  doa_pkg::acc_in_t r11_in,
    input  doa_pkg::acc_in_t r22_in,
    input  doa_pkg::acc_in_t r12_re_in,
    input  doa_pkg::acc_in_t r12_im_in,
    input  logic             din_valid,
    input  logic             frame_start,
    output doa_pkg::sum_t    r11,
    output doa_pkg::sum_t    r22,
    output doa_pkg::sum_t    r12_re,
    output doa_pkg::sum_t    r12_im,
    output doa_pkg::band_t   band_number,
    output logic             dout_valid
);
    import doa_pkg::*;

    logic    active;
    count_t  idx;
    count_t  pos;
    logic    take;
    logic    band_first;
    logic    band_last;
    acc_in_t lane_in [4];
    sum_t    run [4];
    sum_t    nxt [4];

    always_comb begin
        lane_in[0] = r11_in;
        lane_in[1] = r22_in;
        lane_in[2] = r12_re_in;
        lane_in[3] = r12_im_in;
        // a frame start always counts as sample 0
        pos = frame_start ? '0 : idx;
        take = din_valid && (frame_start || active);
        band_first = (pos % band_step) == 0;
        band_last = (pos % band_step) == band_step - 1;
        for (int i = 0; i < 4; i++) begin
            nxt[i] = band_first ? sum_t'(lane_in[i]) : run[i] + sum_t'(lane_in[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            idx <= '0;
        end else if (take) begin
            idx <= pos + 1'b1;
            // frame closes after its last sample
            active <= (pos != vector_len - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            run <= nxt;
        end
        if (take && band_last) begin
            r11 <= nxt[0];
            r22 <= nxt[1];
            r12_re <= nxt[2];
            r12_im <= nxt[3];
            band_number <= band_t'(pos / band_step);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= take && band_last;
        end
    end

endmodule

// ==== design/band_doa.sv ====
`timescale 1ns/1ns

module band_doa (
    input  logic             clk,
    input  logic             rst,
    input  doa_pkg::sample_t din1_re,
    input  doa_pkg::sample_t din1_im,
    input  doa_pkg::sample_t din2_re,
    input  doa_pkg::sample_t din2_im,
    input  logic             din_valid,
    input  logic             new_acc,
    output doa_pkg::sum_t    r11,
    output doa_pkg::sum_t    r22,
    output doa_pkg::sum_t    r12_re,
    output doa_pkg::sum_t    r12_im,
    output doa_pkg::band_t   band_number,
    output logic             dout_valid
);
    import doa_pkg::*;

    sample_t din1_re_r;
    sample_t din1_im_r;
    sample_t din2_re_r;
    sample_t din2_im_r;
    logic    din_valid_r;
    logic    new_acc_r;
    // transform 1 + mults 2 + cast 1
    logic [3:0] new_acc_line;

    trans_t y1_re;
    trans_t y1_im;
    trans_t y2_re;
    trans_t y2_im;
    logic   trans_valid;

    prod_t r11_prod;
    prod_t r22_prod;
    prod_t r12_re_prod;
    prod_t r12_im_prod;
    logic  prod_valid;

    logic [4*acc_in_width-1:0] cast_bus;
    logic [3:0]                cast_valid;

    always_ff @(posedge clk) begin
        din1_re_r <= din1_re;
        din1_im_r <= din1_im;
        din2_re_r <= din2_re;
        din2_im_r <= din2_im;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            din_valid_r <= 1'b0;
            new_acc_r <= 1'b0;
            new_acc_line <= '0;
        end else begin
            din_valid_r <= din_valid;
            new_acc_r <= new_acc;
            new_acc_line <= {new_acc_line[2:0], new_acc_r};
        end
    end

    centrosym_matrix centrosym_inst (
        .clk(clk), .rst(rst),
        .x1_re(din1_re_r), .x1_im(din1_im_r), .x2_re(din2_re_r), .x2_im(din2_im_r),
        .din_valid(din_valid_r),
        .y1_re(y1_re), .y1_im(y1_im), .y2_re(y2_re), .y2_im(y2_im),
        .dout_valid(trans_valid)
    );

    correlation_mults mults_inst (
        .clk(clk), .rst(rst),
        .y1_re(y1_re), .y1_im(y1_im), .y2_re(y2_re), .y2_im(y2_im),
        .din_valid(trans_valid),
        .r11(r11_prod), .r22(r22_prod), .r12_re(r12_re_prod), .r12_im(r12_im_prod),
        .dout_valid(prod_valid)
    );

    // lane 3 is r11 down to lane 0 for r12_im
    signed_cast cast_inst [3:0] (
        .clk(clk), .rst(rst),
        .din({r11_prod, r22_prod, r12_re_prod, r12_im_prod}),
        .din_valid(prod_valid),
        .dout(cast_bus),
        .dout_valid(cast_valid)
    );

    band_accumulator acc_inst (
        .clk(clk), .rst(rst),
        .r11_in(cast_bus[3*acc_in_width +: acc_in_width]),
        .r22_in(cast_bus[2*acc_in_width +: acc_in_width]),
        .r12_re_in(cast_bus[acc_in_width +: acc_in_width]),
        .r12_im_in(cast_bus[0 +: acc_in_width]),
        // lanes run in lockstep
        .din_valid(&cast_valid),
        .frame_start(new_acc_line[3]),
        .r11(r11), .r22(r22), .r12_re(r12_re), .r12_im(r12_im),
        .band_number(band_number),
        .dout_valid(dout_valid)
    );

endmodule

// ==== bench/band_doa_checker.sv ====
`timescale 1ns/1ns

module band_doa_checker (
    input logic           clk,
    input logic           rst,
    input logic           dout_valid,
    input doa_pkg::band_t band_number
);
    import doa_pkg::*;

    band_t prev_band;
    logic  seen_result;
    int    failures = 0;

    // last band seen since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_result <= 1'b0;
            prev_band <= '0;
        end else if (dout_valid) begin
            seen_result <= 1'b1;
            prev_band <= band_number;
        end
    end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !dout_valid)
    else begin
        $error("dout_valid high in the cycle after reset");
        failures++;
    end

    single_pulse: assert property (@(posedge clk) disable iff (rst)
        dout_valid |=> !dout_valid)
    else begin
        $error("dout_valid held for two cycles");
        failures++;
    end

    // restart at band 0 or step by one
    band_order: assert property (@(posedge clk) disable iff (rst)
        (dout_valid && seen_result) |->
        (band_number == '0 || band_number == band_t'(prev_band + 1'b1)))
    else begin
        $error("band_number out of order");
        failures++;
    end

endmodule

// ==== bench/band_doa_tb.sv ====
`timescale 1ns/1ns

module band_doa_tb;
    import doa_pkg::*;

    // 50 stimulus lines at up to 4 cycles each, plus drain margin
    localparam int cycle_limit = 400;

    logic    clk;
    logic    rst;
    sample_t din1_re;
    sample_t din1_im;
    sample_t din2_re;
    sample_t din2_im;
    logic    din_valid;
    logic    new_acc;
    sum_t    r11;
    sum_t    r22;
    sum_t    r12_re;
    sum_t    r12_im;
    band_t   band_number;
    logic    dout_valid;

    // one entry per S line
    logic    stim_new [$];
    sample_t stim_x1_re [$];
    sample_t stim_x1_im [$];
    sample_t stim_x2_re [$];
    sample_t stim_x2_im [$];

    // expected results in output order
    band_t exp_band [$];
    sum_t  exp_r11 [$];
    sum_t  exp_r22 [$];
    sum_t  exp_re [$];
    sum_t  exp_im [$];

    integer seed;
    int     cycles;
    int     band_errors;
    int     power_errors;
    int     cross_errors;
    int     other_errors;

    band_doa DUT (
        .clk(clk), .rst(rst),
        .din1_re(din1_re), .din1_im(din1_im), .din2_re(din2_re), .din2_im(din2_im),
        .din_valid(din_valid), .new_acc(new_acc),
        .r11(r11), .r22(r22), .r12_re(r12_re), .r12_im(r12_im),
        .band_number(band_number), .dout_valid(dout_valid)
    );

    bind band_doa band_doa_checker checker_inst (
        .clk(clk), .rst(rst), .dout_valid(dout_valid), .band_number(band_number)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    v0, v1, v2, v3, v4;
        string line;
        fd = $fopen("bench/band_doa_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file bench/band_doa_stimulus.txt could not be opened");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2) begin
                continue;
            end
            n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
                        v0, v1, v2, v3, v4);
            if (line[0] == "S" && n == 5) begin
                stim_new.push_back(v0 != 0);
                stim_x1_re.push_back(sample_t'(v1));
                stim_x1_im.push_back(sample_t'(v2));
                stim_x2_re.push_back(sample_t'(v3));
                stim_x2_im.push_back(sample_t'(v4));
            end else if (line[0] == "E" && n == 5) begin
                exp_band.push_back(band_t'(v0));
                exp_r11.push_back(sum_t'(v1));
                exp_r22.push_back(sum_t'(v2));
                exp_re.push_back(sum_t'(v3));
                exp_im.push_back(sum_t'(v4));
            end else if (line[0] != "#") begin
                $display("malformed stimulus line: %s", line);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_band(input band_t got, input band_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: band_number %0d, expected %0d", $time, got, exp);
            band_errors++;
        end
    endtask

    task automatic check_power(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            power_errors++;
        end
    endtask

    task automatic check_cross(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            cross_errors++;
        end
    endtask

    task automatic end_run();
        int assert_errors;
        int total;
        assert_errors = DUT.checker_inst.failures;
        total = band_errors + power_errors + cross_errors + other_errors + assert_errors;
        $display("errors: band %0d, power %0d, cross %0d, missing or extra %0d, assertion %0d",
                 band_errors, power_errors, cross_errors, other_errors, assert_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (!rst && dout_valid) begin
            if (exp_band.size() == 0) begin
                $display("extra result at %0t ns for band %0d, none was expected",
                         $time, band_number);
                other_errors++;
            end else begin
                check_band(band_number, exp_band.pop_front());
                check_power("r11", r11, exp_r11.pop_front());
                check_power("r22", r22, exp_r22.pop_front());
                check_cross("r12_re", r12_re, exp_re.pop_front());
                check_cross("r12_im", r12_im, exp_im.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected results never arrived",
                     cycles, exp_band.size());
            other_errors += exp_band.size() + 1;
            end_run();
        end
    end

    initial begin
        int gap;
        int frame_pos;
        int copies;
        rst = 1'b1;
        din1_re = '0;
        din1_im = '0;
        din2_re = '0;
        din2_im = '0;
        din_valid = 1'b0;
        new_acc = 1'b0;
        seed = 32'h3995;
        cycles = 0;
        band_errors = 0;
        power_errors = 0;
        cross_errors = 0;
        other_errors = 0;
        load_stimulus();
        // no frame is open until the first new_acc
        frame_pos = vector_len;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (stim_new[i]) begin
            if (stim_new[i]) begin
                frame_pos = 0;
            end
            // a sample outside any frame goes in a whole band's worth of times
            copies = (frame_pos >= vector_len) ? band_step : 1;
            frame_pos++;
            repeat (copies) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(posedge clk);
                    din_valid <= 1'b0;
                    new_acc <= 1'b0;
                end
                @(posedge clk);
                din_valid <= 1'b1;
                new_acc <= stim_new[i];
                din1_re <= stim_x1_re[i];
                din1_im <= stim_x1_im[i];
                din2_re <= stim_x2_re[i];
                din2_im <= stim_x2_im[i];
            end
        end
        @(posedge clk);
        din_valid <= 1'b0;
        new_acc <= 1'b0;
        while (exp_band.size() != 0) begin
            @(posedge clk);
        end
        // long enough for a stray result to show up
        repeat (12) @(posedge clk);
        end_run();
    end

endmodule

// ==== bench/band_doa_stimulus.txt ====
# S new_acc x1_re x1_im x2_re x2_im   (signed decimal antenna samples)
# E band r11 r22 r12_re r12_im        (expected band sums, in output order)
S 0 500 -500 250 -250
S 1 32 0 0 0
S 0 0 32 0 0
S 0 32 32 32 32
S 0 64 0 0 32
S 0 0 0 32 0
S 0 0 0 0 32
S 0 32 64 -32 0
S 0 96 -32 32 64
S 0 1 0 0 0
S 0 0 0 1 0
S 0 16 0 0 16
S 0 64 64 64 64
S 0 -64 32 0 0
S 0 0 -96 0 0
S 0 32 32 -32 -32
S 0 128 0 0 0
S 1 32 0 0 0
S 0 0 64 32 0
S 0 32 32 0 0
S 0 0 0 0 64
S 0 160 160 160 160
S 0 96 -96 32 0
S 1 32767 32767 32767 32767
S 0 32767 32767 32767 32767
S 0 32767 32767 32767 32767
S 0 32767 32767 32767 32767
S 0 32767 32767 -32768 32767
S 0 32767 32767 -32768 32767
S 0 32767 32767 -32768 32767
S 0 32767 32767 -32768 32767
S 0 0 0 -32768 -32768
S 0 0 0 -32768 -32768
S 0 0 0 -32768 -32768
S 0 0 0 -32768 -32768
S 0 -32768 32767 32767 32767
S 0 -32768 32767 32767 32767
S 0 -32768 32767 32767 32767
S 0 -32768 32767 32767 32767
S 0 100 200 300 400
E 0 15 7 -4 5
E 1 23 23 -18 7
E 2 32 0 -1 -1
E 3 30 38 0 30
E 0 12 12 4 2
E 0 2097148 0 0 0
E 1 2097148 2097148 -2097152 -256
E 2 2097148 2097148 0 -2097152
E 3 2097148 2097148 2097148 252

// ==== compile.f ====
design/doa_pkg.sv
design/centrosym_matrix.sv
design/correlation_mults.sv
design/signed_cast.sv
design/band_accumulator.sv
design/band_doa.sv
bench/band_doa_checker.sv
bench/band_doa_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module band_doa_tb \
		-f compile.f -Mdir obj_dir
	@out=$$(./obj_dir/Vband_doa_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
